// ==== Bender.yml ====
package:
  name: mem_1r1w

sources:
  - files:
      - hw/mem_pkg.sv
      - hw/row_counter.sv
      - hw/init_fsm.sv
      - hw/bank_ram.sv
      - hw/bank_mux.sv
      - hw/mem_1r1w_top.sv
  - target: test
    files:
      - tb/mem_1r1w_asserts.sv
      - tb/mem_1r1w_tb.sv

// ==== hw/bank_mux.sv ====
`timescale 1ns/100ps

module bank_mux import mem_pkg::*; (
  input  logic                                  clk,
  input  logic                                  rst_n,
  // primary port.
  input  logic                                  pwrite,
  input  logic [bank_bits-1:0]                  pwr_bank,
  input  logic [row_bits-1:0]                   pwr_row,
  input  logic [data_width-1:0]                 pdin,
  input  logic                                  pread,
  input  logic [bank_bits-1:0]                  prd_bank,
  input  logic [row_bits-1:0]                   prd_row,
  output rd_result_t                            presult,
  // metadata table.
  input  logic                                  tbl_write,
  input  logic [row_bits-1:0]                   tbl_row,
  input  meta_word_u                            tbl_din,
  input  logic                                  sread1,
  input  logic [row_bits-1:0]                   srd_row1,
  input  logic                                  sread2,
  input  logic [row_bits-1:0]                   srd_row2,
  output meta_word_u                            smeta1,
  output logic                                  sfwrd1,
  output logic [padr_bits-1:0]                  spadr1,
  output meta_word_u                            smeta2,
  output logic                                  sfwrd2,
  output logic [padr_bits-1:0]                  spadr2,
  // data bank RAMs.
  output logic [num_banks-1:0]                  bank_write,
  output logic [num_banks-1:0]                  bank_read,
  output logic [num_banks-1:0][row_bits-1:0]    bank_wr_row,
  output logic [num_banks-1:0][row_bits-1:0]    bank_rd_row,
  output logic [num_banks-1:0][data_width-1:0]  bank_din,
  input  logic [num_banks-1:0][data_width-1:0]  bank_dout,
  input  logic [num_banks-1:0]                  bank_fwrd,
  input  logic [num_banks-1:0][padr_bits-1:0]   bank_padr,
  // metadata copies. copy_row is indexed [copy][0 = write, 1 = read].
  output logic [1:0]                            copy_write,
  output logic [1:0]                            copy_read,
  output logic [1:0][1:0][row_bits-1:0]         copy_row,
  output logic [1:0][meta_width-1:0]            copy_din,
  input  logic [1:0][meta_width-1:0]            copy_dout,
  input  logic [1:0]                            copy_fwrd,
  input  logic [1:0][padr_bits-1:0]             copy_padr
);

  logic [read_delay-2:0]                rd_vld;
  logic [read_delay-1:0][bank_bits-1:0] rd_bank;
  logic [bank_bits-1:0]                 rd_sel;

  always_comb begin
    for (int b = 0; b < num_banks; b++) begin
      bank_write[b]  = pwrite && (pwr_bank == bank_bits'(b));
      bank_read[b]   = pread && (prd_bank == bank_bits'(b));
      bank_wr_row[b] = pwr_row;
      bank_rd_row[b] = prd_row;
      bank_din[b]    = pdin;
    end
  end

  // bank number follows its read through the RAM latency.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_vld  <= '0;
      rd_bank <= '0;
    end else begin
      rd_vld[0] <= pread;
      if (pread) begin
        rd_bank[0] <= prd_bank;
      end
      for (int i = 1; i < read_delay; i++) begin
        if (i < read_delay - 1) begin
          rd_vld[i] <= rd_vld[i-1];
        end
        if (rd_vld[i-1]) begin
          rd_bank[i] <= rd_bank[i-1];
        end
      end
    end
  end

  assign rd_sel = rd_bank[read_delay-1];

  always_comb begin
    presult.data = bank_dout[rd_sel];
    presult.fwrd = bank_fwrd[rd_sel];
    presult.padr = bank_padr[rd_sel];
  end

  // both copies take every write; each read port owns one copy.
  always_comb begin
    for (int c = 0; c < 2; c++) begin
      copy_write[c]  = tbl_write;
      copy_row[c][0] = tbl_row;
      copy_din[c]    = tbl_din.raw;
    end
    copy_read      = {sread2, sread1};
    copy_row[0][1] = srd_row1;
    copy_row[1][1] = srd_row2;
  end

  assign smeta1.raw = copy_dout[0];
  assign sfwrd1     = copy_fwrd[0];
  assign spadr1     = copy_padr[0];
  assign smeta2.raw = copy_dout[1];
  assign sfwrd2     = copy_fwrd[1];
  assign spadr2     = copy_padr[1];

endmodule

// ==== hw/bank_ram.sv ====
`timescale 1ns/100ps

module bank_ram import mem_pkg::*; #(
  parameter int width      = data_width,
  parameter int bank_index = 0
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 write,
  input  logic [row_bits-1:0]  wr_row,
  input  logic [width-1:0]     din,
  input  logic                 read,
  input  logic [row_bits-1:0]  rd_row,
  output logic [width-1:0]     dout,
  output logic                 fwrd,
  output logic [padr_bits-1:0] padr
);

  logic [width-1:0]                      mem [num_rows];
  logic [read_delay-1:0][width-1:0]     data_q;
  logic [read_delay-1:0]                 fwrd_q;
  logic [read_delay-1:0][padr_bits-1:0] padr_q;
  logic [read_delay-2:0]                 vld_q;
  logic                                  hit;

  // same-row read and write in one cycle returns the new word.
  assign hit = write && read && (wr_row == rd_row);

  always_ff @(posedge clk) begin
    if (write) begin
      mem[wr_row] <= din;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else begin
      vld_q[0] <= read;
      for (int i = 1; i < read_delay - 1; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  // each stage only moves when it carries a read, so the output holds.
  always_ff @(posedge clk) begin
    if (read) begin
      data_q[0] <= hit ? din : mem[rd_row];
      fwrd_q[0] <= hit;
      padr_q[0] <= {bank_bits'(bank_index), rd_row};
    end
    for (int i = 1; i < read_delay; i++) begin
      if (vld_q[i-1]) begin
        data_q[i] <= data_q[i-1];
        fwrd_q[i] <= fwrd_q[i-1];
        padr_q[i] <= padr_q[i-1];
      end
    end
  end

  assign dout = data_q[read_delay-1];
  assign fwrd = fwrd_q[read_delay-1];
  assign padr = padr_q[read_delay-1];

endmodule

// ==== hw/init_fsm.sv ====
`timescale 1ns/100ps

module init_fsm import mem_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                swrite,
  input  logic [row_bits-1:0] swr_row,
  input  meta_word_u          sdin,
  input  logic [row_bits-1:0] row,
  input  logic                last,
  output logic                cnt_enable,
  output logic                tbl_write,
  output logic [row_bits-1:0] tbl_row,
  output meta_word_u          tbl_din,
  output logic                init_busy
);

  typedef enum logic [1:0] {
    idle_reset,
    sweep,
    ready
  } state_t;

  state_t state;
  state_t state_nxt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= idle_reset;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      idle_reset: state_nxt = sweep;
      sweep:      if (last) state_nxt = ready;
      default:    state_nxt = ready;
    endcase
  end

  assign cnt_enable = (state == sweep);
  assign init_busy  = (state != ready);

  // external writes are dropped until the table is clear.
  always_comb begin
    tbl_write = (state == ready) && swrite;
    tbl_row   = swr_row;
    tbl_din   = sdin;
    if (state == sweep) begin
      tbl_write = 1'b1;
      tbl_row   = row;
      tbl_din   = '0;
    end
  end

endmodule

// ==== hw/mem_1r1w_top.sv ====
`timescale 1ns/100ps

module mem_1r1w_top import mem_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  pwrite,
  input  logic [bank_bits-1:0]  pwr_bank,
  input  logic [row_bits-1:0]   pwr_row,
  input  logic [data_width-1:0] pdin,
  input  logic                  pread,
  input  logic [bank_bits-1:0]  prd_bank,
  input  logic [row_bits-1:0]   prd_row,
  output rd_result_t            presult,
  input  logic                  swrite,
  input  logic [row_bits-1:0]   swr_row,
  input  meta_word_u            sdin,
  input  logic                  sread1,
  input  logic [row_bits-1:0]   srd_row1,
  input  logic                  sread2,
  input  logic [row_bits-1:0]   srd_row2,
  output meta_word_u            smeta1,
  output logic                  sfwrd1,
  output logic [padr_bits-1:0]  spadr1,
  output meta_word_u            smeta2,
  output logic                  sfwrd2,
  output logic [padr_bits-1:0]  spadr2,
  output logic                  init_busy
);

  logic [num_banks-1:0]                 bank_write;
  logic [num_banks-1:0]                 bank_read;
  logic [num_banks-1:0][row_bits-1:0]   bank_wr_row;
  logic [num_banks-1:0][row_bits-1:0]   bank_rd_row;
  logic [num_banks-1:0][data_width-1:0] bank_din;
  logic [num_banks-1:0][data_width-1:0] bank_dout;
  logic [num_banks-1:0]                 bank_fwrd;
  logic [num_banks-1:0][padr_bits-1:0]  bank_padr;
  logic [1:0]                           copy_write;
  logic [1:0]                           copy_read;
  logic [1:0][1:0][row_bits-1:0]        copy_row;
  logic [1:0][meta_width-1:0]           copy_din;
  logic [1:0][meta_width-1:0]           copy_dout;
  logic [1:0]                           copy_fwrd;
  logic [1:0][padr_bits-1:0]            copy_padr;
  logic                                 tbl_write;
  logic [row_bits-1:0]                  tbl_row;
  meta_word_u                           tbl_din;
  logic [row_bits-1:0]                  row;
  logic                                 last;
  logic                                 cnt_enable;

  // counter parks at zero once the sweep is done.
  row_counter u_row_counter (
    .clk    (clk),
    .rst_n  (rst_n),
    .clear  (~init_busy),
    .enable (cnt_enable),
    .row    (row),
    .last   (last)
  );

  init_fsm u_init_fsm (
    .clk        (clk),
    .rst_n      (rst_n),
    .swrite     (swrite),
    .swr_row    (swr_row),
    .sdin       (sdin),
    .row        (row),
    .last       (last),
    .cnt_enable (cnt_enable),
    .tbl_write  (tbl_write),
    .tbl_row    (tbl_row),
    .tbl_din    (tbl_din),
    .init_busy  (init_busy)
  );

  bank_mux u_bank_mux (
    .clk         (clk),
    .rst_n       (rst_n),
    .pwrite      (pwrite),
    .pwr_bank    (pwr_bank),
    .pwr_row     (pwr_row),
    .pdin        (pdin),
    .pread       (pread),
    .prd_bank    (prd_bank),
    .prd_row     (prd_row),
    .presult     (presult),
    .tbl_write   (tbl_write),
    .tbl_row     (tbl_row),
    .tbl_din     (tbl_din),
    .sread1      (sread1),
    .srd_row1    (srd_row1),
    .sread2      (sread2),
    .srd_row2    (srd_row2),
    .smeta1      (smeta1),
    .sfwrd1      (sfwrd1),
    .spadr1      (spadr1),
    .smeta2      (smeta2),
    .sfwrd2      (sfwrd2),
    .spadr2      (spadr2),
    .bank_write  (bank_write),
    .bank_read   (bank_read),
    .bank_wr_row (bank_wr_row),
    .bank_rd_row (bank_rd_row),
    .bank_din    (bank_din),
    .bank_dout   (bank_dout),
    .bank_fwrd   (bank_fwrd),
    .bank_padr   (bank_padr),
    .copy_write  (copy_write),
    .copy_read   (copy_read),
    .copy_row    (copy_row),
    .copy_din    (copy_din),
    .copy_dout   (copy_dout),
    .copy_fwrd   (copy_fwrd),
    .copy_padr   (copy_padr)
  );

  for (genvar b = 0; b < num_banks; b++) begin : g_bank
    bank_ram #(
      .width      (data_width),
      .bank_index (b)
    ) u_bank (
      .clk    (clk),
      .rst_n  (rst_n),
      .write  (bank_write[b]),
      .wr_row (bank_wr_row[b]),
      .din    (bank_din[b]),
      .read   (bank_read[b]),
      .rd_row (bank_rd_row[b]),
      .dout   (bank_dout[b]),
      .fwrd   (bank_fwrd[b]),
      .padr   (bank_padr[b])
    );
  end

  // metadata copies, one per read port.
  for (genvar c = 0; c < 2; c++) begin : g_copy
    bank_ram #(
      .width      (meta_width),
      .bank_index (c)
    ) u_copy (
      .clk    (clk),
      .rst_n  (rst_n),
      .write  (copy_write[c]),
      .wr_row (copy_row[c][0]),
      .din    (copy_din[c]),
      .read   (copy_read[c]),
      .rd_row (copy_row[c][1]),
      .dout   (copy_dout[c]),
      .fwrd   (copy_fwrd[c]),
      .padr   (copy_padr[c])
    );
  end

endmodule

// ==== hw/mem_pkg.sv ====
package mem_pkg;

  localparam int data_width = 32;
  localparam int num_banks  = 8;
  localparam int bank_bits  = $clog2(num_banks);
  localparam int num_rows   = 64;
  localparam int row_bits   = $clog2(num_rows);
  localparam int ecc_bits   = 4;

  // two bank-map entries, each a valid bit plus a bank number.
  localparam int map_bits   = 2 * (bank_bits + 1);
  localparam int meta_width = data_width + map_bits + ecc_bits;

  // physical address is bank number over row.
  localparam int padr_bits  = bank_bits + row_bits;

  // read latency of every RAM copy, in cycles.
  localparam int read_delay = 2;

  typedef struct packed {
    logic                 valid;
    logic [bank_bits-1:0] bank;
  } map_entry_t;

  typedef struct packed {
    map_entry_t            map_entry1;
    map_entry_t            map_entry0;
    logic [ecc_bits-1:0]   ecc;
    logic [data_width-1:0] payload;
  } meta_fields_t;

  // the RAM copies store raw bits, users decode the fields.
  typedef union packed {
    logic [meta_width-1:0] raw;
    meta_fields_t          fields;
  } meta_word_u;

  typedef struct packed {
    logic [data_width-1:0] data;
    logic                  fwrd;
    logic [padr_bits-1:0]  padr;
  } rd_result_t;

endpackage

// ==== hw/row_counter.sv ====
`timescale 1ns/100ps

module row_counter import mem_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                clear,
  input  logic                enable,
  output logic [row_bits-1:0] row,
  output logic                last
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      row <= '0;
    end else if (clear) begin
      row <= '0;
    end else if (enable) begin
      row <= row + 1'b1;
    end
  end

  // marks the final row of the sweep.
  assign last = (row == row_bits'(num_rows - 1));

endmodule

// ==== mem_1r1w_top.f ====
hw/mem_pkg.sv
hw/row_counter.sv
hw/init_fsm.sv
hw/bank_ram.sv
hw/bank_mux.sv
hw/mem_1r1w_top.sv
tb/mem_1r1w_asserts.sv
tb/mem_1r1w_tb.sv

// ==== tb/mem_1r1w_asserts.sv ====
`timescale 1ns/100ps

module mem_1r1w_asserts import mem_pkg::*; (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  pwrite,
  input logic [bank_bits-1:0]  pwr_bank,
  input logic [row_bits-1:0]   pwr_row,
  input logic [data_width-1:0] pdin,
  input logic                  pread,
  input logic [bank_bits-1:0]  prd_bank,
  input logic [row_bits-1:0]   prd_row,
  input rd_result_t            presult,
  input logic                  swrite,
  input logic [row_bits-1:0]   swr_row,
  input meta_word_u            sdin,
  input logic                  sread1,
  input logic [row_bits-1:0]   srd_row1,
  input logic                  sread2,
  input logic [row_bits-1:0]   srd_row2,
  input meta_word_u            smeta1,
  input logic                  sfwrd1,
  input logic [padr_bits-1:0]  spadr1,
  input meta_word_u            smeta2,
  input logic                  sfwrd2,
  input logic [padr_bits-1:0]  spadr2,
  input logic                  init_busy
);

  int                    fail_count = 0;
  int                    busy_cycles;
  logic [data_width-1:0] data_shadow [num_banks][num_rows];
  logic                  data_known  [num_banks][num_rows];
  meta_word_u            meta_shadow [num_rows];
  logic                  p_hit;
  logic                  p_chk;
  logic [data_width-1:0] p_exp;
  logic                  s_hit1;
  logic                  s_hit2;
  meta_word_u            s_exp1;
  meta_word_u            s_exp2;

  // the sweep leaves every metadata row at zero.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < num_rows; r++) begin
        meta_shadow[r] <= '0;
        for (int b = 0; b < num_banks; b++) begin
          data_known[b][r] <= 1'b0;
        end
      end
      busy_cycles <= 0;
    end else begin
      if (pwrite) begin
        data_shadow[pwr_bank][pwr_row] <= pdin;
        data_known[pwr_bank][pwr_row]  <= 1'b1;
      end
      if (swrite && !init_busy) begin
        meta_shadow[swr_row] <= sdin;
      end
      if (init_busy) begin
        busy_cycles <= busy_cycles + 1;
      end
    end
  end

  assign p_hit  = pwrite && pread && (pwr_bank == prd_bank) && (pwr_row == prd_row);
  assign p_chk  = pread && (p_hit || data_known[prd_bank][prd_row]);
  assign p_exp  = p_hit ? pdin : data_shadow[prd_bank][prd_row];
  assign s_hit1 = swrite && !init_busy && (swr_row == srd_row1);
  assign s_hit2 = swrite && !init_busy && (swr_row == srd_row2);
  assign s_exp1 = s_hit1 ? sdin : meta_shadow[srd_row1];
  assign s_exp2 = s_hit2 ? sdin : meta_shadow[srd_row2];

  a_reset_busy: assert property (@(posedge clk) !rst_n |-> init_busy)
    else begin
      fail_count++;
      $error("init_busy is low while reset is asserted");
    end

  // one idle_reset cycle comes ahead of the num_rows sweep cycles.
  a_busy_length: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(init_busy) |-> busy_cycles == num_rows + 1)
    else begin
      fail_count++;
      $error("mismatch at %0t: init_busy high for %0d cycles", $time, busy_cycles);
    end

  a_busy_stays_low: assert property (@(posedge clk) disable iff (!rst_n)
    !init_busy |=> !init_busy)
    else begin
      fail_count++;
      $error("init_busy rose again after the sweep finished");
    end

  a_primary_data: assert property (@(posedge clk) disable iff (!rst_n)
    p_chk |-> ##2 (presult.data == $past(p_exp, 2) && presult.fwrd == $past(p_hit, 2)))
    else begin
      fail_count++;
      $error("mismatch at %0t: primary read data %h fwrd %b", $time,
             presult.data, presult.fwrd);
    end

  a_primary_padr: assert property (@(posedge clk) disable iff (!rst_n)
    pread |-> ##2 presult.padr == $past({prd_bank, prd_row}, 2))
    else begin
      fail_count++;
      $error("mismatch at %0t: primary padr %h", $time, presult.padr);
    end

  a_meta_port1: assert property (@(posedge clk) disable iff (!rst_n)
    sread1 && !init_busy |-> ##2 (smeta1.fields == $past(s_exp1.fields, 2) &&
      sfwrd1 == $past(s_hit1, 2) && spadr1 == {bank_bits'(0), $past(srd_row1, 2)}))
    else begin
      fail_count++;
      $error("mismatch at %0t: port 1 meta %h fwrd %b padr %h", $time,
             smeta1.raw, sfwrd1, spadr1);
    end

  a_meta_port2: assert property (@(posedge clk) disable iff (!rst_n)
    sread2 && !init_busy |-> ##2 (smeta2.fields == $past(s_exp2.fields, 2) &&
      sfwrd2 == $past(s_hit2, 2) && spadr2 == {bank_bits'(1), $past(srd_row2, 2)}))
    else begin
      fail_count++;
      $error("mismatch at %0t: port 2 meta %h fwrd %b padr %h", $time,
             smeta2.raw, sfwrd2, spadr2);
    end

endmodule

bind mem_1r1w_top mem_1r1w_asserts u_asserts (.*);

// ==== tb/mem_1r1w_tb.sv ====
`timescale 1ns/100ps

module mem_1r1w_tb import mem_pkg::*; ();

  localparam int cycle_limit = 3 * (num_rows + 200);

  logic                  clk;
  logic                  rst_n;
  logic                  pwrite;
  logic [bank_bits-1:0]  pwr_bank;
  logic [row_bits-1:0]   pwr_row;
  logic [data_width-1:0] pdin;
  logic                  pread;
  logic [bank_bits-1:0]  prd_bank;
  logic [row_bits-1:0]   prd_row;
  rd_result_t            presult;
  logic                  swrite;
  logic [row_bits-1:0]   swr_row;
  meta_word_u            sdin;
  logic                  sread1;
  logic [row_bits-1:0]   srd_row1;
  logic                  sread2;
  logic [row_bits-1:0]   srd_row2;
  meta_word_u            smeta1;
  logic                  sfwrd1;
  logic [padr_bits-1:0]  spadr1;
  meta_word_u            smeta2;
  logic                  sfwrd2;
  logic [padr_bits-1:0]  spadr2;
  logic                  init_busy;

  logic [31:0]           lcg_state = 32'h7277c9a2;
  logic [padr_bits-1:0]  addr_q [$];
  logic [row_bits-1:0]   row_q [$];
  int                    cycles;
  int                    errors;

  mem_1r1w_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic next_rand(output logic [31:0] r);
    lcg_state = lcg_step(lcg_state);
    r = lcg_state;
  endtask

  task automatic random_meta(output meta_word_u w);
    logic [31:0] r0;
    logic [31:0] r1;
    next_rand(r0);
    next_rand(r1);
    w.fields.payload    = r0;
    w.fields.ecc        = r1[11:8];
    w.fields.map_entry0 = r1[15:12];
    w.fields.map_entry1 = r1[19:16];
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    pwrite <= 1'b0;
    pread  <= 1'b0;
    swrite <= 1'b0;
    sread1 <= 1'b0;
    sread2 <= 1'b0;
  endtask

  // rows already swept, so a write that slipped through would show up later.
  task automatic write_during_sweep();
    meta_word_u w;
    repeat (8) @(posedge clk);
    for (int i = 0; i < 4; i++) begin
      random_meta(w);
      @(posedge clk);
      swrite  <= 1'b1;
      swr_row <= row_bits'(i);
      sdin    <= w;
    end
    idle_cycle();
  endtask

  task automatic wait_sweep_done();
    @(posedge clk);
    while (init_busy) begin
      @(posedge clk);
    end
  endtask

  task automatic read_all_meta();
    for (int i = 0; i < num_rows; i++) begin
      @(posedge clk);
      sread1   <= 1'b1;
      srd_row1 <= row_bits'(i);
      sread2   <= 1'b1;
      srd_row2 <= row_bits'(num_rows - 1 - i);
    end
    idle_cycle();
  endtask

  task automatic primary_write_read();
    logic [31:0] r;
    logic [31:0] d;
    for (int i = 0; i < 40; i++) begin
      next_rand(r);
      next_rand(d);
      @(posedge clk);
      pwrite   <= 1'b1;
      pwr_bank <= r[31:29];
      pwr_row  <= r[28:23];
      pdin     <= d;
      addr_q.push_back(r[31:23]);
    end
    idle_cycle();
    while (addr_q.size() > 0) begin
      @(posedge clk);
      {prd_bank, prd_row} <= addr_q.pop_front();
      pread <= 1'b1;
    end
    idle_cycle();
  endtask

  task automatic primary_same_cycle();
    logic [31:0] r;
    logic [31:0] d;
    for (int i = 0; i < 8; i++) begin
      next_rand(r);
      next_rand(d);
      @(posedge clk);
      pwrite   <= 1'b1;
      pread    <= 1'b1;
      pwr_bank <= r[31:29];
      prd_bank <= r[31:29];
      pwr_row  <= r[28:23];
      prd_row  <= r[28:23];
      pdin     <= d;
    end
    idle_cycle();
  endtask

  // one row from each group of eight keeps the rows distinct.
  task automatic meta_write_pairs();
    logic [31:0] r;
    meta_word_u  w;
    for (int i = 0; i < 8; i++) begin
      next_rand(r);
      random_meta(w);
      row_q.push_back(row_bits'(8 * i) | row_bits'(r[31:29]));
      @(posedge clk);
      swrite  <= 1'b1;
      swr_row <= row_q[i];
      sdin    <= w;
    end
    idle_cycle();
    for (int i = 0; i < 8; i++) begin
      @(posedge clk);
      sread1   <= 1'b1;
      srd_row1 <= row_q[i];
      sread2   <= 1'b1;
      srd_row2 <= row_q[(i + 1) % 8];
    end
    idle_cycle();
  endtask

  task automatic meta_same_cycle();
    logic [31:0] r;
    meta_word_u  w;
    for (int i = 0; i < 4; i++) begin
      next_rand(r);
      random_meta(w);
      @(posedge clk);
      swrite   <= 1'b1;
      swr_row  <= r[31:26];
      sdin     <= w;
      sread1   <= 1'b1;
      srd_row1 <= r[31:26];
      sread2   <= 1'b1;
      srd_row2 <= r[31:26];
    end
    idle_cycle();
  endtask

  initial begin
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("run timeout: the tests did not finish within %0d cycles", cycle_limit);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    rst_n    = 1'b0;
    pwrite   = 1'b0;
    pwr_bank = '0;
    pwr_row  = '0;
    pdin     = '0;
    pread    = 1'b0;
    prd_bank = '0;
    prd_row  = '0;
    swrite   = 1'b0;
    swr_row  = '0;
    sdin     = '0;
    sread1   = 1'b0;
    srd_row1 = '0;
    sread2   = 1'b0;
    srd_row2 = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    write_during_sweep();
    wait_sweep_done();
    read_all_meta();
    primary_write_read();
    primary_same_cycle();
    meta_write_pairs();
    meta_same_cycle();
    repeat (read_delay + 2) @(posedge clk);
    errors = u_dut.u_asserts.fail_count;
    $display("assertion failures: %0d after %0d cycles", errors, cycles);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
